// ==== logic/riscv_pkg.sv ====
// widths, register file size, major opcodes, class flags and reset values of the core
package riscv_pkg;

    localparam int xlen     = 32;                     // data and address width
    localparam int num_regs = 32;                     // full rv32i register set

    typedef logic [xlen-1:0]             word_t;      // data or address word
    typedef logic [$clog2(num_regs)-1:0] reg_addr_t;  // register index
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  funct7_t;
    typedef logic [xlen/8-1:0]           byte_en_t;   // one enable per byte lane

    // major opcodes, fence and system are left out and run as no-ops
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // one-hot class flags, filled by the fetch stage
    typedef struct packed {
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic bcc;    // conditional branch
        logic lcc;    // load
        logic scc;    // store
        logic mcc;    // reg-imm alu
        logic rcc;    // reg-reg alu
    } inst_class_t;

    localparam word_t     reset_pc   = 32'h0000_0000;  // first fetch address
    localparam word_t     reset_sp   = 32'h0000_1000;  // initial stack top
    localparam reg_addr_t sp_index   = 5'd2;           // x2
    localparam word_t     inst_bytes = 32'd4;          // sequential pc step

endpackage

// ==== logic/decode_if.sv ====
// pre-decoded instruction bundle from fetch stage to the execute modules
`timescale 1ns/1ns

interface decode_if;

    riscv_pkg::inst_class_t cls;      // class flags, already zero while flushed
    riscv_pkg::reg_addr_t   rd_ptr;   // destination
    riscv_pkg::reg_addr_t   rs1_ptr;
    riscv_pkg::reg_addr_t   rs2_ptr;
    riscv_pkg::funct3_t     funct3;   // alu op, branch cond, access size
    riscv_pkg::funct7_t     funct7;   // sub/sra select in bit 5
    riscv_pkg::word_t       simm;     // sign extended immediate
    riscv_pkg::word_t       uimm;     // zero extended immediate

    // fetch stage side
    modport producer (
        output cls, rd_ptr, rs1_ptr, rs2_ptr,
        output funct3, funct7, simm, uimm
    );

    // execute side, read only
    modport consumer (
        input cls, rd_ptr, rs1_ptr, rs2_ptr,
        input funct3, funct7, simm, uimm
    );

endinterface

// ==== logic/fetch_decode.sv ====
// fetch stage with instruction latch, class pre-decode, immediate builders and flush gating
`timescale 1ns/1ns

module fetch_decode
(
    input  logic              CLK,
    input  logic              hlt,
    input  logic              sweep_active,
    input  logic              flush,
    input  riscv_pkg::word_t  idata,
    decode_if.producer        dec
);

    riscv_pkg::opcode_t     opc;      // major opcode of incoming word
    riscv_pkg::word_t       sfill;    // copies of bit 31
    riscv_pkg::inst_class_t cls_d;
    riscv_pkg::inst_class_t cls_q;
    riscv_pkg::word_t       simm_d;
    riscv_pkg::word_t       uimm_d;
    riscv_pkg::word_t       simm_q;
    riscv_pkg::word_t       uimm_q;
    riscv_pkg::word_t       inst_q;   // word now in execute

    assign opc   = riscv_pkg::opcode_t'(idata[6:0]);
    assign sfill = {riscv_pkg::xlen{idata[31]}};

    always_comb
    begin
        cls_d       = '0;
        cls_d.lui   = (opc == riscv_pkg::op_lui);
        cls_d.auipc = (opc == riscv_pkg::op_auipc);
        cls_d.jal   = (opc == riscv_pkg::op_jal);
        cls_d.jalr  = (opc == riscv_pkg::op_jalr);
        cls_d.bcc   = (opc == riscv_pkg::op_branch);
        cls_d.lcc   = (opc == riscv_pkg::op_load);
        cls_d.scc   = (opc == riscv_pkg::op_store);
        cls_d.mcc   = (opc == riscv_pkg::op_imm);
        cls_d.rcc   = (opc == riscv_pkg::op_reg);
    end

    // immediate by format, i-type covers jalr, loads and reg-imm alu
    always_comb
    begin
        case (opc)
            riscv_pkg::op_store:
            begin
                simm_d = {sfill[31:12], idata[31:25], idata[11:7]};          // s-type
                uimm_d = {20'b0, idata[31:25], idata[11:7]};
            end
            riscv_pkg::op_branch:
            begin
                simm_d = {sfill[31:13], idata[31], idata[7], idata[30:25], idata[11:8], 1'b0};
                uimm_d = {19'b0, idata[31], idata[7], idata[30:25], idata[11:8], 1'b0};
            end
            riscv_pkg::op_jal:
            begin
                simm_d = {sfill[31:21], idata[31], idata[19:12], idata[20], idata[30:21], 1'b0};
                uimm_d = {11'b0, idata[31], idata[19:12], idata[20], idata[30:21], 1'b0};
            end
            riscv_pkg::op_lui, riscv_pkg::op_auipc:
            begin
                simm_d = {idata[31:12], 12'b0};                              // u-type
                uimm_d = {idata[31:12], 12'b0};
            end
            default:
            begin
                simm_d = {sfill[31:12], idata[31:20]};                       // i-type
                uimm_d = {20'b0, idata[31:20]};
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (sweep_active)
        begin
            inst_q <= '0;       // nothing decoded during sweep
            cls_q  <= '0;
            simm_q <= '0;
            uimm_q <= '0;
        end
        else if (!hlt)
        begin
            inst_q <= idata;
            cls_q  <= cls_d;
            simm_q <= simm_d;
            uimm_q <= uimm_d;
        end
    end

    assign dec.cls     = flush ? '0 : cls_q;   // kill slot behind a taken jump
    assign dec.rd_ptr  = inst_q[11:7];
    assign dec.rs1_ptr = inst_q[19:15];
    assign dec.rs2_ptr = inst_q[24:20];
    assign dec.funct3  = inst_q[14:12];
    assign dec.funct7  = inst_q[31:25];
    assign dec.simm    = simm_q;
    assign dec.uimm    = uimm_q;

endmodule

// ==== logic/reg_file.sv ====
// register file as two mirrored copies with one read port each, reset sweep and x0 rule
`timescale 1ns/1ns

module reg_file
(
    input  logic                  CLK,
    input  logic                  hlt,
    input  logic                  sweep_active,
    input  riscv_pkg::reg_addr_t  sweep_ptr,
    decode_if.consumer            dec,
    input  riscv_pkg::word_t      wb_data,
    output riscv_pkg::word_t      rs1_val,
    output riscv_pkg::word_t      rs2_val
);

    riscv_pkg::word_t     regs_a [riscv_pkg::num_regs];  // rs1 copy
    riscv_pkg::word_t     regs_b [riscv_pkg::num_regs];  // rs2 copy
    riscv_pkg::reg_addr_t waddr;
    riscv_pkg::word_t     wdata;
    logic                 writes_rd;                     // class has a destination
    logic                 we;

    assign writes_rd = dec.cls.lui | dec.cls.auipc | dec.cls.jal | dec.cls.jalr |
                       dec.cls.lcc | dec.cls.mcc | dec.cls.rcc;

    always_comb
    begin
        if (sweep_active)
        begin
            waddr = sweep_ptr;                       // walk every register
            wdata = (sweep_ptr == riscv_pkg::sp_index) ? riscv_pkg::reset_sp : '0;
            we    = 1'b1;
        end
        else
        begin
            waddr = dec.rd_ptr;
            wdata = wb_data;
            we    = writes_rd && (dec.rd_ptr != '0); // x0 stays zero
        end
    end

    // both copies written together
    always_ff @(posedge CLK)
    begin
        if (we && !hlt)
        begin
            regs_a[waddr] <= wdata;
            regs_b[waddr] <= wdata;
        end
    end

    assign rs1_val = regs_a[dec.rs1_ptr];
    assign rs2_val = regs_b[dec.rs2_ptr];

endmodule

// ==== logic/alu.sv ====
// register and immediate arithmetic, logic, shifts and branch compare
`timescale 1ns/1ns

module alu
(
    decode_if.consumer         dec,
    input  riscv_pkg::word_t   rs1_val,
    input  riscv_pkg::word_t   rs2_val,
    output riscv_pkg::word_t   rm_result,
    output logic               branch_taken
);

    riscv_pkg::word_t op2;       // immediate for op_imm, else rs2
    riscv_pkg::word_t sra_val;   // arithmetic shift kept apart from the mux
    logic [4:0]       shamt;
    logic             lt_s;
    logic             lt_u;
    logic             eq;
    logic             cond;      // branch condition by funct3

    assign op2     = dec.cls.mcc ? dec.simm : rs2_val;
    assign shamt   = dec.cls.mcc ? dec.uimm[4:0] : rs2_val[4:0];
    assign sra_val = $signed(rs1_val) >>> shamt;

    // compares shared by slt/sltu and branches, op2 is rs2 for branches
    assign lt_s = $signed(rs1_val) < $signed(op2);
    assign lt_u = rs1_val < op2;
    assign eq   = (rs1_val == op2);

    always_comb
    begin
        case (dec.funct3)
            3'd0:    rm_result = (dec.cls.rcc && dec.funct7[5]) ? rs1_val - op2 : rs1_val + op2;
            3'd1:    rm_result = rs1_val << shamt;                               // sll
            3'd2:    rm_result = {{(riscv_pkg::xlen-1){1'b0}}, lt_s};            // slt
            3'd3:    rm_result = {{(riscv_pkg::xlen-1){1'b0}}, lt_u};            // sltu
            3'd4:    rm_result = rs1_val ^ op2;
            3'd5:    rm_result = dec.funct7[5] ? sra_val : rs1_val >> shamt;     // sra/srl
            3'd6:    rm_result = rs1_val | op2;
            default: rm_result = rs1_val & op2;
        endcase
    end

    always_comb
    begin
        case (dec.funct3)
            3'd0:    cond = eq;      // beq
            3'd1:    cond = !eq;     // bne
            3'd4:    cond = lt_s;    // blt
            3'd5:    cond = !lt_s;   // bge
            3'd6:    cond = lt_u;    // bltu
            3'd7:    cond = !lt_u;   // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.cls.bcc && cond;

endmodule

// ==== logic/lsu.sv ====
// data address, store lane placement, byte enables and load extraction
`timescale 1ns/1ns

module lsu
(
    decode_if.consumer          dec,
    input  riscv_pkg::word_t    rs1_val,
    input  riscv_pkg::word_t    rs2_val,
    input  riscv_pkg::word_t    datai,
    output riscv_pkg::word_t    daddr,
    output riscv_pkg::word_t    datao,
    output riscv_pkg::word_t    load_data,
    output riscv_pkg::byte_en_t be,
    output logic                rd,
    output logic                wr
);

    logic [1:0]       lane;       // byte offset in word
    logic             sext;       // lb/lh, not lbu/lhu
    riscv_pkg::word_t byte_src;   // addressed byte moved to bits 7:0
    riscv_pkg::word_t half_src;   // addressed half moved to bits 15:0

    assign daddr = rs1_val + dec.simm;   // also the jalr target
    assign lane  = daddr[1:0];
    assign rd    = dec.cls.lcc;
    assign wr    = dec.cls.scc;

    // store data in its lane, other lanes zero
    always_comb
    begin
        case (dec.funct3[1:0])
            2'd0:
            begin
                be    = 4'b0001 << lane;
                datao = riscv_pkg::word_t'(rs2_val[7:0]) << {lane, 3'b000};
            end
            2'd1:
            begin
                be    = 4'b0011 << {lane[1], 1'b0};
                datao = riscv_pkg::word_t'(rs2_val[15:0]) << {lane[1], 4'b0000};
            end
            default:
            begin
                be    = 4'b1111;   // word
                datao = rs2_val;
            end
        endcase
    end

    assign sext     = !dec.funct3[2];
    assign byte_src = datai >> {lane, 3'b000};
    assign half_src = datai >> {lane[1], 4'b0000};

    always_comb
    begin
        case (dec.funct3[1:0])
            2'd0:    load_data = {{24{sext & byte_src[7]}}, byte_src[7:0]};
            2'd1:    load_data = {{16{sext & half_src[15]}}, half_src[15:0]};
            default: load_data = datai;
        endcase
    end

endmodule

// ==== logic/pc_control.sv ====
// program counters, jump target, flush flag and register reset sweep sequencer
`timescale 1ns/1ns

module pc_control
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  hlt,
    input  logic                  branch_taken,
    decode_if.consumer            dec,
    input  riscv_pkg::word_t      daddr,
    output riscv_pkg::word_t      pc,
    output riscv_pkg::word_t      next_pc,
    output logic                  flush,
    output logic                  sweep_active,
    output riscv_pkg::reg_addr_t  sweep_ptr
);

    logic             jreq;          // taken jal, jalr or branch
    riscv_pkg::word_t jump_target;

    assign jreq        = dec.cls.jal | dec.cls.jalr | branch_taken;
    assign jump_target = dec.cls.jalr ? {daddr[riscv_pkg::xlen-1:1], 1'b0}  // rs1+imm, bit 0 cleared
                                      : pc + dec.simm;

    // sweep counts top register down to x0, one per unhalted cycle
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            sweep_active <= 1'b1;
            sweep_ptr    <= riscv_pkg::reg_addr_t'(riscv_pkg::num_regs - 1);
        end
        else if (!hlt && sweep_active)
        begin
            sweep_active <= (sweep_ptr != '0);   // last write is x0
            sweep_ptr    <= sweep_ptr - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rst || sweep_active)
        begin
            next_pc <= riscv_pkg::reset_pc;
            pc      <= riscv_pkg::reset_pc;
            flush   <= 1'b1;                     // keeps one idle slot after sweep
        end
        else if (!hlt)
        begin
            next_pc <= jreq ? jump_target : next_pc + riscv_pkg::inst_bytes;
            pc      <= next_pc;                  // address of word being latched
            flush   <= jreq;                     // drop the fall-through fetch
        end
    end

endmodule

// ==== logic/riscv_core.sv ====
// two-stage rv32i core top level with writeback select and bus wiring
`timescale 1ns/1ns

module riscv_core
(
    input  logic                CLK,
    input  logic                rst,
    input  logic                hlt,     // freezes the whole core
    input  riscv_pkg::word_t    idata,
    input  riscv_pkg::word_t    datai,
    output riscv_pkg::word_t    iaddr,
    output riscv_pkg::word_t    datao,
    output riscv_pkg::word_t    daddr,
    output riscv_pkg::byte_en_t be,
    output logic                wr,
    output logic                rd,
    output logic                idle
);

    decode_if dec ();

    riscv_pkg::word_t     rs1_val;
    riscv_pkg::word_t     rs2_val;
    riscv_pkg::word_t     rm_result;
    riscv_pkg::word_t     load_data;
    riscv_pkg::word_t     pc;
    riscv_pkg::word_t     next_pc;    // also the link value
    riscv_pkg::word_t     pc_simm;    // auipc result
    riscv_pkg::word_t     wb_data;
    riscv_pkg::reg_addr_t sweep_ptr;
    logic                 branch_taken;
    logic                 flush;
    logic                 sweep_active;

    assign pc_simm = pc + dec.simm;

    // writeback by class, alu result as fallback
    assign wb_data = dec.cls.auipc                 ? pc_simm   :
                     (dec.cls.jal || dec.cls.jalr) ? next_pc   :
                     dec.cls.lui                   ? dec.simm  :
                     dec.cls.lcc                   ? load_data :
                                                     rm_result;

    assign iaddr = next_pc;
    assign idle  = flush;   // no instruction in execute

    fetch_decode u_fetch_decode (
        .CLK          (CLK),
        .hlt          (hlt),
        .sweep_active (sweep_active),
        .flush        (flush),
        .idata        (idata),
        .dec          (dec.producer)
    );

    reg_file u_reg_file (
        .CLK          (CLK),
        .hlt          (hlt),
        .sweep_active (sweep_active),
        .sweep_ptr    (sweep_ptr),
        .dec          (dec.consumer),
        .wb_data      (wb_data),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val)
    );

    alu u_alu (
        .dec          (dec.consumer),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .rm_result    (rm_result),
        .branch_taken (branch_taken)
    );

    lsu u_lsu (
        .dec          (dec.consumer),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .datai        (datai),
        .daddr        (daddr),
        .datao        (datao),
        .load_data    (load_data),
        .be           (be),
        .rd           (rd),
        .wr           (wr)
    );

    pc_control u_pc_control (
        .CLK          (CLK),
        .rst          (rst),
        .hlt          (hlt),
        .branch_taken (branch_taken),
        .dec          (dec.consumer),
        .daddr        (daddr),
        .pc           (pc),
        .next_pc      (next_pc),
        .flush        (flush),
        .sweep_active (sweep_active),
        .sweep_ptr    (sweep_ptr)
    );

endmodule

// ==== verif/riscv_core_properties.sv ====
// concurrent assertions on the core's bus and control outputs, bound to riscv_core
`timescale 1ns/1ns

module riscv_core_properties
(
    input logic                CLK,
    input logic                rst,
    input logic                hlt,
    input logic                rd,
    input logic                wr,
    input logic                idle,
    input riscv_pkg::word_t    iaddr,
    input riscv_pkg::word_t    daddr,
    input riscv_pkg::word_t    datao,
    input riscv_pkg::byte_en_t be
);

    // one access kind per cycle
    assert property (@(posedge CLK) disable iff (rst) !(rd && wr))
        else $error("rd and wr high in the same cycle");

    // frozen core keeps its outputs
    assert property (@(posedge CLK) disable iff (rst)
        hlt |=> ($stable(iaddr) && $stable(daddr) && $stable(datao) && $stable(be) &&
                 $stable(rd) && $stable(wr) && $stable(idle)))
        else $error("outputs changed while hlt was high");

    assert property (@(posedge CLK) disable iff (rst) idle |-> (!rd && !wr))
        else $error("bus access while idle");

endmodule

bind riscv_core riscv_core_properties u_riscv_core_properties (
    .CLK   (CLK),
    .rst   (rst),
    .hlt   (hlt),
    .rd    (rd),
    .wr    (wr),
    .idle  (idle),
    .iaddr (iaddr),
    .daddr (daddr),
    .datao (datao),
    .be    (be)
);

// ==== verif/tb_riscv_core.sv ====
// testbench for riscv_core with lfsr program generator, memories, instruction-set model and checks
`timescale 1ns/1ns

module tb_riscv_core;

    localparam int prog_len  = 64;
    localparam int win_words = 16;                        // data window 0x400..0x43f
    localparam int quiet     = 16;                        // cycles watched after the self loop

    logic                CLK;
    logic                rst;
    logic                hlt;
    logic                hlt_on;                          // random hlt enable
    riscv_pkg::word_t    idata;
    riscv_pkg::word_t    datai;
    riscv_pkg::word_t    iaddr;
    riscv_pkg::word_t    datao;
    riscv_pkg::word_t    daddr;
    riscv_pkg::byte_en_t be;
    logic                wr;
    logic                rd;
    logic                idle;

    logic [31:0]         lfsr;
    riscv_pkg::word_t    prog [prog_len];
    riscv_pkg::word_t    dmem [win_words];
    logic                acc_wr   [prog_len];             // model access list
    riscv_pkg::word_t    acc_addr [prog_len];
    riscv_pkg::byte_en_t acc_be   [prog_len];
    riscv_pkg::word_t    acc_dat  [prog_len];
    int                  n_acc;
    int                  acc_idx;
    int                  n_exec;                          // instructions the model ran
    int                  limit;                           // watchdog cycles

    riscv_core u_riscv_core (
        .CLK   (CLK),
        .rst   (rst),
        .hlt   (hlt),
        .idata (idata),
        .datai (datai),
        .iaddr (iaddr),
        .datao (datao),
        .daddr (daddr),
        .be    (be),
        .wr    (wr),
        .rd    (rd),
        .idle  (idle)
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;                                // 40 ns period

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic riscv_pkg::word_t fill_word(input riscv_pkg::word_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;       // every address bit matters
    endfunction

    function automatic riscv_pkg::byte_en_t lane_be(input logic [1:0] size, input logic [1:0] ln);
        if (size == 2'd0)
            return riscv_pkg::byte_en_t'(4'b0001 << ln);
        else if (size == 2'd1)
            return riscv_pkg::byte_en_t'(4'b0011 << ln);
        return 4'b1111;
    endfunction

    function automatic riscv_pkg::word_t be_mask(input riscv_pkg::byte_en_t b);
        riscv_pkg::word_t m;
        for (int j = 0; j < 4; j++)
            m[8*j +: 8] = {8{b[j]}};
        return m;
    endfunction

    // instruction word follows iaddr and data memory answers in the same cycle
    assign idata = (iaddr[31:8] == '0) ? prog[iaddr[7:2]] : 32'h0000_0013;
    assign datai = (daddr[31:6] == 26'h10) ? dmem[daddr[5:2]] : fill_word(daddr);

    always @(posedge CLK)
    begin
        if (!rst && !hlt && wr && daddr[31:6] == 26'h10)
            for (int j = 0; j < 4; j++)
                if (be[j])
                    dmem[daddr[5:2]][8*j +: 8] <= datao[8*j +: 8];
    end

    always @(posedge CLK)
    begin
        if (hlt_on)
            hlt <= (take_bits(2) == 2'd0);                // about one cycle in four
    end

    task automatic abort_run;
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input riscv_pkg::word_t got,
                              input riscv_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_be(input string name, input riscv_pkg::byte_en_t got,
                            input riscv_pkg::byte_en_t exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // every counted access against the model list in order
    always @(posedge CLK)
    begin
        if (!hlt && (rd || wr))
        begin
            if (acc_idx >= n_acc)
            begin
                $display("the core made a data access the program does not contain");
                abort_run();
            end
            check_flag("wr", wr, acc_wr[acc_idx]);
            check_flag("rd", rd, !acc_wr[acc_idx]);
            check_word("daddr", daddr, acc_addr[acc_idx]);
            check_be("be", be, acc_be[acc_idx]);
            if (wr)
                check_word("datao", datao & be_mask(be), acc_dat[acc_idx] & be_mask(be));
            acc_idx++;
        end
    end

    // random program with a store of x2 first and a self jump last
    task automatic gen_program;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [1:0]  size;
        logic [1:0]  ln;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [4:0]  rd_f;                                        // x0..x7 only
        logic [4:0]  rs1_f;
        logic [4:0]  rs2_f;
        logic [4:0]  sh_f;                                        // shift amount
        logic        alt;                                         // funct7 bit 5 or variant
        int          tgt;
        prog[0] = {7'h20, 5'd2, 5'd0, 3'd2, 5'd0, 7'b0100011};    // store x2 at 0x400
        for (int i = 1; i < prog_len - 1; i++)
        begin
            kind  = 4'(take_bits(4));
            f3    = 3'(take_bits(3));
            rd_f  = 5'(take_bits(3));
            rs1_f = 5'(take_bits(3));
            rs2_f = 5'(take_bits(3));
            sh_f  = 5'(take_bits(5));
            alt   = 1'(take_bits(1));
            tgt   = i + 1 + int'(take_bits(2));
            if (tgt > prog_len - 1)
                tgt = prog_len - 1;
            size = 2'(take_bits(2) % 3);
            ln   = 2'(take_bits(2)) & ((size == 2'd0) ? 2'b11 : (size == 2'd1) ? 2'b10 : 2'b00);
            imm  = 12'h400 + {4'(take_bits(4)), 2'b00} + 12'(ln);   // window address
            if (kind <= 4'd4)
            begin
                if (f3 == 3'd1)
                    prog[i] = {7'd0, sh_f, rs1_f, f3, rd_f, 7'b0010011};
                else if (f3 == 3'd5)
                    prog[i] = {1'b0, alt, 5'd0, sh_f, rs1_f, f3, rd_f, 7'b0010011};
                else
                    prog[i] = {12'(take_bits(12)), rs1_f, f3, rd_f, 7'b0010011};
            end
            else if (kind <= 4'd7)
                prog[i] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? alt : 1'b0, 5'd0,
                           rs2_f, rs1_f, f3, rd_f, 7'b0110011};
            else if (kind == 4'd8)
                prog[i] = {20'(take_bits(20)), rd_f, 7'b0110111};
            else if (kind == 4'd9)
                prog[i] = {20'(take_bits(20)), rd_f, 7'b0010111};
            else if (kind <= 4'd11)                               // sb/sh/sw off x0
                prog[i] = {imm[11:5], rs2_f, 5'd0, 1'b0, size, imm[4:0], 7'b0100011};
            else if (kind <= 4'd13)                               // lb/lh/lw/lbu/lhu
                prog[i] = {imm, 5'd0, ((size != 2'd2) && alt), size, rd_f, 7'b0000011};
            else if (kind == 4'd14)
            begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 ^ 3'd2;                               // only valid conditions
                boff    = 13'((tgt - i) * 4);
                prog[i] = {boff[12], boff[10:5], rs2_f, rs1_f, f3, boff[4:1],
                           boff[11], 7'b1100011};
            end
            else if (alt)
            begin
                joff    = 21'((tgt - i) * 4);
                prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd_f, 7'b1101111};
            end
            else
                prog[i] = {12'(tgt * 4), 5'd0, 3'd0, rd_f, 7'b1100111};  // jalr x0 base
        end
        prog[prog_len-1] = 32'h0000_006f;                         // jal to itself
    endtask

    // instruction-set model from the rv32i rules up to the self loop
    task automatic run_model;
        riscv_pkg::word_t xr [32];
        riscv_pkg::word_t mm [win_words];
        riscv_pkg::word_t ins;
        riscv_pkg::word_t a;
        riscv_pkg::word_t b;
        riscv_pkg::word_t imm;
        riscv_pkg::word_t res;
        riscv_pkg::word_t addr;
        riscv_pkg::word_t w;
        riscv_pkg::word_t pc;
        riscv_pkg::word_t npc;
        logic             wb;
        logic             cond;
        logic [4:0]       sh;
        logic [1:0]       sz;
        for (int r = 0; r < 32; r++)
            xr[r] = '0;
        xr[2] = riscv_pkg::reset_sp;
        for (int k = 0; k < win_words; k++)
            mm[k] = fill_word(32'h400 + 4 * k);
        pc = '0;
        n_acc  = 0;
        n_exec = 0;
        while (pc != 4 * (prog_len - 1))
        begin
            ins  = prog[pc[7:2]];
            a    = xr[ins[19:15]];
            b    = xr[ins[24:20]];
            imm  = {{20{ins[31]}}, ins[31:20]};
            npc  = pc + 4;
            wb   = 1'b1;
            res  = '0;
            sh   = (ins[6:0] == 7'b0010011) ? ins[24:20] : b[4:0];
            b    = (ins[6:0] == 7'b0010011) ? imm : b;            // second operand
            sz   = ins[13:12];
            case (ins[6:0])
                7'b0010011, 7'b0110011:
                begin
                    case (ins[14:12])
                        3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1: res = a << sh;
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5:
                        begin
                            if (ins[30])
                                res = $signed(a) >>> sh;
                            else
                                res = a >> sh;
                        end
                        3'd6: res = a | b;
                        3'd7: res = a & b;
                    endcase
                end
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0010111: res = pc + {ins[31:12], 12'b0};
                7'b1101111:
                begin
                    res = npc;
                    npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100111:
                begin
                    res = npc;
                    npc = (a + imm) & ~32'd1;
                end
                7'b1100011:
                begin
                    wb = 1'b0;
                    b  = xr[ins[24:20]];
                    case (ins[14:12])
                        3'd0:    cond = (a == b);
                        3'd1:    cond = (a != b);
                        3'd4:    cond = $signed(a) < $signed(b);
                        3'd5:    cond = $signed(a) >= $signed(b);
                        3'd6:    cond = a < b;
                        default: cond = a >= b;
                    endcase
                    if (cond)
                        npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'b0000011:
                begin
                    addr = a + imm;
                    w    = mm[addr[5:2]] >> (8 * addr[1:0]);
                    if (sz == 2'd0)
                        res = {{24{!ins[14] & w[7]}}, w[7:0]};
                    else if (sz == 2'd1)
                        res = {{16{!ins[14] & w[15]}}, w[15:0]};
                    else
                        res = w;
                    acc_wr[n_acc]   = 1'b0;
                    acc_addr[n_acc] = addr;
                    acc_be[n_acc]   = lane_be(sz, addr[1:0]);
                    acc_dat[n_acc]  = '0;
                    n_acc++;
                end
                7'b0100011:
                begin
                    wb   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    w    = xr[ins[24:20]] << (8 * addr[1:0]);      // value moved to its lane
                    acc_wr[n_acc]   = 1'b1;
                    acc_addr[n_acc] = addr;
                    acc_be[n_acc]   = lane_be(sz, addr[1:0]);
                    acc_dat[n_acc]  = w;
                    mm[addr[5:2]]   = (mm[addr[5:2]] & ~be_mask(acc_be[n_acc])) |
                                      (w & be_mask(acc_be[n_acc]));
                    n_acc++;
                end
                default: wb = 1'b0;
            endcase
            if (wb && ins[11:7] != 5'd0)
                xr[ins[11:7]] = res;
            pc = npc;
            n_exec++;
        end
    endtask

    initial
    begin
        wait (limit > 0);
        repeat (limit) @(posedge CLK);
        $display("watchdog expired before the program finished");
        abort_run();
    end

    initial
    begin
        rst     = 1'b1;
        hlt     = 1'b0;
        hlt_on  = 1'b0;
        acc_idx = 0;
        n_acc   = 0;
        lfsr    = 32'h474b;
        for (int k = 0; k < win_words; k++)
            dmem[k] = fill_word(32'h400 + 4 * k);
        gen_program();
        run_model();
        limit = 4 * (n_exec + quiet) + riscv_pkg::num_regs + 8;
        for (int k = 0; k < 4; k++)                               // four reset cycles
        begin
            @(posedge CLK);
            if (k == 3)
                rst <= 1'b0;
            @(negedge CLK);
            check_flag("idle", idle, 1'b1);
            check_flag("rd", rd, 1'b0);
            check_flag("wr", wr, 1'b0);
            check_word("iaddr", iaddr, riscv_pkg::reset_pc);
        end
        repeat (riscv_pkg::num_regs)                              // rest of the sweep
        begin
            @(negedge CLK);
            check_flag("idle", idle, 1'b1);
            check_flag("rd", rd, 1'b0);
            check_flag("wr", wr, 1'b0);
            check_word("iaddr", iaddr, riscv_pkg::reset_pc);
        end
        hlt_on = 1'b1;
        do
            @(negedge CLK);
        while (!(acc_idx == n_acc && iaddr == 4 * (prog_len - 1)));
        repeat (quiet) @(posedge CLK);                            // no more accesses allowed
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== rv_core.f ====
logic/riscv_pkg.sv
logic/decode_if.sv
logic/fetch_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/lsu.sv
logic/pc_control.sv
logic/riscv_core.sv
verif/riscv_core_properties.sv
verif/tb_riscv_core.sv
